//--- hdl/RenamePkg.sv
`default_nettype none

package RenamePkg;

    // Physical register tag, up to 64 tags
    typedef logic [5:0] PhysTag;

    // Sequence number of an accepted micro-op, wraps at 256
    typedef logic [7:0] SqN;

    // Architectural registers, each one holding a tag at all times
    localparam int archRegCount = 16;

    // First sequence number handed out after reset
    localparam SqN sqNReset = '0;

endpackage

`default_nettype wire

//--- hdl/CorePkg.sv
`default_nettype none

package CorePkg;

    // Architectural register index, x0 is hardwired to zero
    typedef logic [3:0] ArchReg;

    typedef enum logic [1:0] {
        FuInt,
        FuMul,
        FuLd,
        FuSt
    } FuType;

    // Micro-op as it leaves decode
    typedef struct packed {
        logic valid;
        FuType fu;
        ArchReg rd;
        ArchReg rs0;
        ArchReg rs1;
        logic [15:0] imm;
    } DecodedUop;

    // Retiring micro-op, tagDst becomes the committed mapping of archDst
    typedef struct packed {
        logic valid;
        ArchReg archDst;
        RenamePkg::PhysTag tagDst;
    } CommitUop;

    typedef struct packed {
        logic valid;
        RenamePkg::PhysTag tagDst;
    } WbResult;

    // Micro-op after rename, as held in the dispatch queue
    typedef struct packed {
        FuType fu;
        logic [15:0] imm;
        ArchReg archDst;
        RenamePkg::PhysTag tagDst;
        RenamePkg::PhysTag tagA;
        RenamePkg::PhysTag tagB;
        logic availA;
        logic availB;
        RenamePkg::SqN sqN;
    } RenamedUop;

endpackage

`default_nettype wire

//--- hdl/RenameTable.sv
`timescale 1ns/1ps
`default_nettype none

module RenameTable #(
    parameter int laneCount = 2,
    parameter int physTagCount = 32
) (
    input wire clk,
    input wire rst,

    input wire CorePkg::ArchReg lookupRegs [2*laneCount],
    output RenamePkg::PhysTag lookupTags [2*laneCount],
    output logic lookupAvail [2*laneCount],

    input wire allocValid [laneCount],
    input wire CorePkg::ArchReg allocReg [laneCount],
    input wire RenamePkg::PhysTag allocTag [laneCount],

    input wire CorePkg::CommitUop commitUops [laneCount],
    output logic releaseValid [laneCount],
    output RenamePkg::PhysTag releaseTag [laneCount],

    input wire CorePkg::WbResult wbResults [laneCount]
);

    localparam int tagIdxW = $clog2(physTagCount);

    RenamePkg::PhysTag specMap [RenamePkg::archRegCount];
    RenamePkg::PhysTag comMap [RenamePkg::archRegCount];
    logic [physTagCount-1:0] avail;

    // Source lookup, a writeback on this edge already counts as available
    always_comb begin
        for (int i = 0; i < 2*laneCount; i++) begin
            lookupTags[i] = specMap[lookupRegs[i]];
            lookupAvail[i] = avail[lookupTags[i][tagIdxW-1:0]];
            for (int w = 0; w < laneCount; w++) begin
                if (wbResults[w].valid && wbResults[w].tagDst == lookupTags[i]) begin
                    lookupAvail[i] = 1'b1;
                end
            end
        end
    end

    // Tag replaced by each commit lane, an older lane on the same register
    // in this cycle is the one being replaced
    always_comb begin
        for (int i = 0; i < laneCount; i++) begin
            releaseValid[i] = commitUops[i].valid && commitUops[i].archDst != '0;
            releaseTag[i] = comMap[commitUops[i].archDst];
            for (int j = 0; j < i; j++) begin
                if (releaseValid[j] && commitUops[j].archDst == commitUops[i].archDst) begin
                    releaseTag[i] = commitUops[j].tagDst;
                end
            end
        end
    end

    // Later lanes win on the same register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < RenamePkg::archRegCount; r++) begin
                specMap[r] <= RenamePkg::PhysTag'(r);
                comMap[r] <= RenamePkg::PhysTag'(r);
            end
        end else begin
            for (int i = 0; i < laneCount; i++) begin
                if (allocValid[i]) begin
                    specMap[allocReg[i]] <= allocTag[i];
                end
                if (releaseValid[i]) begin
                    comMap[commitUops[i].archDst] <= commitUops[i].tagDst;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            avail <= '1;
        end else begin
            for (int i = 0; i < laneCount; i++) begin
                if (wbResults[i].valid) begin
                    avail[wbResults[i].tagDst[tagIdxW-1:0]] <= 1'b1;
                end
                if (releaseValid[i]) begin
                    avail[commitUops[i].tagDst[tagIdxW-1:0]] <= 1'b1;
                end
            end
            // A fresh tag has no result yet
            for (int i = 0; i < laneCount; i++) begin
                if (allocValid[i]) begin
                    avail[allocTag[i][tagIdxW-1:0]] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/TagBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module TagBuffer #(
    parameter int laneCount = 2,
    parameter int physTagCount = 32
) (
    input wire clk,
    input wire rst,

    input wire [$clog2(laneCount+1)-1:0] allocCount,
    output RenamePkg::PhysTag headTags [laneCount],
    output logic [$clog2(physTagCount):0] freeCount,

    input wire releaseValid [laneCount],
    input wire RenamePkg::PhysTag releaseTag [laneCount]
);

    localparam int ptrW = $clog2(physTagCount);
    localparam int initFree = physTagCount - RenamePkg::archRegCount;

    RenamePkg::PhysTag tagMem [2**ptrW];
    // One extra bit tells a full buffer from an empty one
    logic [ptrW:0] rdPtr;
    logic [ptrW:0] wrPtr;
    logic [ptrW-1:0] relPos [laneCount];
    logic [ptrW:0] relCount;

    assign freeCount = wrPtr - rdPtr;

    always_comb begin
        for (int i = 0; i < laneCount; i++) begin
            headTags[i] = tagMem[rdPtr[ptrW-1:0] + ptrW'(i)];
        end
    end

    // Released tags are packed behind the tail in lane order
    always_comb begin
        logic [ptrW:0] n;
        n = '0;
        for (int i = 0; i < laneCount; i++) begin
            relPos[i] = wrPtr[ptrW-1:0] + n[ptrW-1:0];
            if (releaseValid[i]) begin
                n = n + 1'b1;
            end
        end
        relCount = n;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= (ptrW+1)'(initFree);
            // Tags above the architectural ones start out free, in ascending order
            for (int k = 0; k < initFree; k++) begin
                tagMem[k] <= RenamePkg::PhysTag'(RenamePkg::archRegCount + k);
            end
        end else begin
            rdPtr <= rdPtr + (ptrW+1)'(allocCount);
            wrPtr <= wrPtr + relCount;
            for (int i = 0; i < laneCount; i++) begin
                if (releaseValid[i]) begin
                    tagMem[relPos[i]] <= releaseTag[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/Rename.sv
`timescale 1ns/1ps
`default_nettype none

module Rename #(
    parameter int laneCount = 2,
    parameter int physTagCount = 32,
    parameter int queueDepth = 8
) (
    input wire clk,
    input wire rst,

    input wire CorePkg::DecodedUop inUops [laneCount],
    output logic inReady,

    output CorePkg::ArchReg lookupRegs [2*laneCount],
    input wire RenamePkg::PhysTag lookupTags [2*laneCount],
    input wire lookupAvail [2*laneCount],

    output logic allocValid [laneCount],
    output CorePkg::ArchReg allocReg [laneCount],
    output RenamePkg::PhysTag allocTag [laneCount],
    output logic [$clog2(laneCount+1)-1:0] allocCount,

    input wire RenamePkg::PhysTag headTags [laneCount],
    input wire [$clog2(physTagCount):0] freeCount,

    output logic qWrite [laneCount],
    output CorePkg::RenamedUop qUops [laneCount],
    input wire creditReturn,

    output RenamePkg::SqN nextSqN
);

    localparam int laneCntW = $clog2(laneCount + 1);
    localparam int freeCntW = $clog2(physTagCount) + 1;
    localparam int creditW = $clog2(queueDepth + 1);

    logic [creditW-1:0] credits;
    RenamePkg::SqN sqN;
    RenamePkg::SqN laneSqN [laneCount];
    RenamePkg::SqN bundleEndSqN;
    logic [laneCntW-1:0] validCount;
    logic needTag [laneCount];
    logic anyValid;
    logic accept;
    CorePkg::RenamedUop renamed [laneCount];

    // Conservative, assumes every lane needs a tag and a queue slot
    assign inReady = !rst && freeCount >= freeCntW'(laneCount) && credits >= creditW'(laneCount);
    assign accept = inReady && anyValid;
    assign nextSqN = sqN;

    always_comb begin
        anyValid = 1'b0;
        for (int i = 0; i < laneCount; i++) begin
            anyValid = anyValid || inUops[i].valid;
        end
    end

    // Lookups, tag pairing and sequence numbers in lane order
    always_comb begin
        logic [laneCntW-1:0] slot;
        RenamePkg::SqN seq;
        slot = '0;
        seq = sqN;
        for (int i = 0; i < laneCount; i++) begin
            lookupRegs[2*i] = inUops[i].rs0;
            lookupRegs[2*i+1] = inUops[i].rs1;
            needTag[i] = inUops[i].valid && inUops[i].rd != '0;
            allocValid[i] = accept && needTag[i];
            allocReg[i] = inUops[i].rd;
            allocTag[i] = '0;
            for (int k = 0; k < laneCount; k++) begin
                if (slot == laneCntW'(k)) begin
                    allocTag[i] = headTags[k];
                end
            end
            if (needTag[i]) begin
                slot = slot + 1'b1;
            end
            laneSqN[i] = seq;
            if (inUops[i].valid) begin
                seq = seq + 1'b1;
            end
        end
        allocCount = accept ? slot : '0;
        bundleEndSqN = seq;
        validCount = laneCntW'(seq - sqN);
    end

    // Operands written by an older lane of the same bundle are not ready yet
    always_comb begin
        for (int i = 0; i < laneCount; i++) begin
            renamed[i].fu = inUops[i].fu;
            renamed[i].imm = inUops[i].imm;
            renamed[i].archDst = inUops[i].rd;
            renamed[i].tagDst = needTag[i] ? allocTag[i] : '0;
            renamed[i].tagA = lookupTags[2*i];
            renamed[i].availA = lookupAvail[2*i];
            renamed[i].tagB = lookupTags[2*i+1];
            renamed[i].availB = lookupAvail[2*i+1];
            renamed[i].sqN = laneSqN[i];
            for (int j = 0; j < i; j++) begin
                if (needTag[j] && inUops[j].rd == inUops[i].rs0) begin
                    renamed[i].tagA = allocTag[j];
                    renamed[i].availA = 1'b0;
                end
                if (needTag[j] && inUops[j].rd == inUops[i].rs1) begin
                    renamed[i].tagB = allocTag[j];
                    renamed[i].availB = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= creditW'(queueDepth);
            sqN <= RenamePkg::sqNReset;
            for (int i = 0; i < laneCount; i++) begin
                qWrite[i] <= 1'b0;
            end
        end else begin
            // One credit per micro-op headed for the queue, one back per pop
            credits <= credits - (accept ? creditW'(validCount) : '0)
                + creditW'(creditReturn);
            if (accept) begin
                sqN <= bundleEndSqN;
            end
            for (int i = 0; i < laneCount; i++) begin
                qWrite[i] <= accept && inUops[i].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < laneCount; i++) begin
            qUops[i] <= renamed[i];
        end
    end

endmodule

`default_nettype wire

//--- hdl/DispatchQueue.sv
`timescale 1ns/1ps
`default_nettype none

module DispatchQueue #(
    parameter int laneCount = 2,
    parameter int queueDepth = 8
) (
    input wire clk,
    input wire rst,

    input wire write [laneCount],
    input wire CorePkg::RenamedUop uops [laneCount],

    output logic dispValid,
    output CorePkg::RenamedUop dispUop,
    input wire dispReady,

    output logic creditReturn
);

    localparam int ptrW = $clog2(queueDepth);
    localparam int cntW = $clog2(queueDepth + 1);

    CorePkg::RenamedUop mem [queueDepth];
    logic [ptrW-1:0] rdPtr;
    logic [ptrW-1:0] wrPtr;
    logic [cntW-1:0] count;
    logic [ptrW-1:0] slot [laneCount];
    logic [ptrW:0] writeCount;
    logic pop;

    // Pointer advance for depths that are not a power of two
    function automatic logic [ptrW-1:0] wrapAdd(input logic [ptrW-1:0] base,
                                                  input logic [ptrW:0] off);
        logic [ptrW+1:0] sum;
        sum = (ptrW+2)'(base) + (ptrW+2)'(off);
        if (sum >= (ptrW+2)'(queueDepth)) begin
            sum = sum - (ptrW+2)'(queueDepth);
        end
        return sum[ptrW-1:0];
    endfunction

    assign dispValid = count != '0;
    assign dispUop = mem[rdPtr];
    assign pop = dispValid && dispReady;

    // Written lanes land in consecutive slots
    always_comb begin
        logic [ptrW:0] n;
        n = '0;
        for (int i = 0; i < laneCount; i++) begin
            slot[i] = wrapAdd(wrPtr, n);
            if (write[i]) begin
                n = n + 1'b1;
            end
        end
        writeCount = n;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < laneCount; i++) begin
            if (write[i]) begin
                mem[slot[i]] <= uops[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
            creditReturn <= 1'b0;
        end else begin
            wrPtr <= wrapAdd(wrPtr, writeCount);
            if (pop) begin
                rdPtr <= wrapAdd(rdPtr, (ptrW+1)'(1));
            end
            count <= count + cntW'(writeCount) - cntW'(pop);
            // Slot freed by a pop goes back to rename one cycle later
            creditReturn <= pop;
        end
    end

endmodule

`default_nettype wire

//--- hdl/RenameTop.sv
`timescale 1ns/1ps
`default_nettype none

module RenameTop #(
    parameter int laneCount = 2,
    parameter int physTagCount = 32,
    parameter int queueDepth = 8
) (
    input wire clk,
    input wire rst,

    input wire CorePkg::DecodedUop inUops [laneCount],
    output logic inReady,

    input wire CorePkg::CommitUop commitUops [laneCount],
    input wire CorePkg::WbResult wbResults [laneCount],

    output logic dispValid,
    output CorePkg::RenamedUop dispUop,
    input wire dispReady,

    output RenamePkg::SqN nextSqN
);

    localparam int laneCntW = $clog2(laneCount + 1);
    localparam int freeCntW = $clog2(physTagCount) + 1;

    CorePkg::ArchReg lookupRegs [2*laneCount];
    RenamePkg::PhysTag lookupTags [2*laneCount];
    logic lookupAvail [2*laneCount];
    logic allocValid [laneCount];
    CorePkg::ArchReg allocReg [laneCount];
    RenamePkg::PhysTag allocTag [laneCount];
    logic [laneCntW-1:0] allocCount;
    RenamePkg::PhysTag headTags [laneCount];
    logic [freeCntW-1:0] freeCount;
    logic releaseValid [laneCount];
    RenamePkg::PhysTag releaseTag [laneCount];
    logic qWrite [laneCount];
    CorePkg::RenamedUop qUops [laneCount];
    logic creditReturn;

    Rename #(
        .laneCount(laneCount),
        .physTagCount(physTagCount),
        .queueDepth(queueDepth)
    ) renameStage (
        .clk(clk),
        .rst(rst),
        .inUops(inUops),
        .inReady(inReady),
        .lookupRegs(lookupRegs),
        .lookupTags(lookupTags),
        .lookupAvail(lookupAvail),
        .allocValid(allocValid),
        .allocReg(allocReg),
        .allocTag(allocTag),
        .allocCount(allocCount),
        .headTags(headTags),
        .freeCount(freeCount),
        .qWrite(qWrite),
        .qUops(qUops),
        .creditReturn(creditReturn),
        .nextSqN(nextSqN)
    );

    RenameTable #(
        .laneCount(laneCount),
        .physTagCount(physTagCount)
    ) renameTable (
        .clk(clk),
        .rst(rst),
        .lookupRegs(lookupRegs),
        .lookupTags(lookupTags),
        .lookupAvail(lookupAvail),
        .allocValid(allocValid),
        .allocReg(allocReg),
        .allocTag(allocTag),
        .commitUops(commitUops),
        .releaseValid(releaseValid),
        .releaseTag(releaseTag),
        .wbResults(wbResults)
    );

    TagBuffer #(
        .laneCount(laneCount),
        .physTagCount(physTagCount)
    ) tagBuffer (
        .clk(clk),
        .rst(rst),
        .allocCount(allocCount),
        .headTags(headTags),
        .freeCount(freeCount),
        .releaseValid(releaseValid),
        .releaseTag(releaseTag)
    );

    DispatchQueue #(
        .laneCount(laneCount),
        .queueDepth(queueDepth)
    ) dispatchQueue (
        .clk(clk),
        .rst(rst),
        .write(qWrite),
        .uops(qUops),
        .dispValid(dispValid),
        .dispUop(dispUop),
        .dispReady(dispReady),
        .creditReturn(creditReturn)
    );

endmodule

`default_nettype wire

//--- test/RenameTop_props.sv
`timescale 1ns/1ps
`default_nettype none

module RenameTopProps #(
    parameter int laneCount = 2,
    parameter int queueDepth = 8
) (
    input wire clk,
    input wire rst,
    input wire [$clog2(queueDepth+1)-1:0] credits,
    input wire [$clog2(queueDepth+1)-1:0] count,
    input wire qWrite [laneCount],
    input wire creditReturn,
    input wire allocValid [laneCount],
    input wire RenamePkg::PhysTag allocTag [laneCount]
);

    int inFlight;

    always_comb begin
        inFlight = 0;
        for (int i = 0; i < laneCount; i++) begin
            inFlight = inFlight + int'(qWrite[i]);
        end
    end

    creditBound: assert property (@(posedge clk) disable iff (rst)
        int'(credits) <= queueDepth)
        else $error("credits above queue depth");

    // Every slot is either free, occupied, or on its way in or out
    slotBalance: assert property (@(posedge clk) disable iff (rst)
        int'(count) + int'(credits) + inFlight + int'(creditReturn) == queueDepth)
        else $error("queue slots out of balance");

    // Tag 0 stays with x0 and is never handed out
    for (genvar i = 0; i < laneCount; i++) begin : laneChecks
        allocRange: assert property (@(posedge clk) disable iff (rst)
            allocValid[i] |-> allocTag[i] != '0)
            else $error("tag of x0 allocated");
    end

endmodule

bind RenameTop RenameTopProps #(
    .laneCount(laneCount),
    .queueDepth(queueDepth)
) props_i (
    .clk(clk),
    .rst(rst),
    .credits(renameStage.credits),
    .count(dispatchQueue.count),
    .qWrite(qWrite),
    .creditReturn(creditReturn),
    .allocValid(allocValid),
    .allocTag(allocTag)
);

`default_nettype wire

//--- test/RenameTb.sv
`timescale 1ns/1ps
`default_nettype none

module RenameTb;

    localparam int lanes = 2;
    localparam int depth = 8;
    // About 200 bundles of three cycles each, plus the shorter tests
    localparam int cycleLimit = 4000;

    logic clk;
    logic rst;
    CorePkg::DecodedUop inUops [lanes];
    logic inReady;
    CorePkg::CommitUop commitUops [lanes];
    CorePkg::WbResult wbResults [lanes];
    logic dispValid;
    CorePkg::RenamedUop dispUop;
    logic dispReady;
    RenamePkg::SqN nextSqN;

    // Reference model state
    RenamePkg::PhysTag specMap [RenamePkg::archRegCount];
    RenamePkg::PhysTag comMap [RenamePkg::archRegCount];
    logic avail [64];
    RenamePkg::PhysTag freeQ [$];
    CorePkg::RenamedUop expQ [$];
    CorePkg::CommitUop commitQ [$];
    RenamePkg::SqN modelSqN;

    logic [31:0] lfsr;
    logic randomReady;
    int errors;
    int cycles;

    RenameTop dut_i (
        .clk(clk),
        .rst(rst),
        .inUops(inUops),
        .inReady(inReady),
        .commitUops(commitUops),
        .wbResults(wbResults),
        .dispValid(dispValid),
        .dispUop(dispUop),
        .dispReady(dispReady),
        .nextSqN(nextSqN)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    task automatic takeBits(input int n, output logic [31:0] val);
        logic b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
            val = {val[30:0], b};
        end
    endtask

    always @(posedge clk) begin
        logic [31:0] r;
        if (randomReady) begin
            takeBits(1, r);
            dispReady <= r[0];
        end
    end

    task automatic compareUop(input CorePkg::RenamedUop exp, input CorePkg::RenamedUop act);
        if (exp !== act) begin
            $display("[FAIL] %0t dispUop expected %h actual %h", $time, exp, act);
            errors++;
        end
    endtask

    task automatic compareSqN(input RenamePkg::SqN exp, input RenamePkg::SqN act);
        if (exp !== act) begin
            $display("[FAIL] %0t nextSqN expected %h actual %h", $time, exp, act);
            errors++;
        end
    endtask

    task automatic compareReady(input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %0t inReady expected %b actual %b", $time, exp, act);
            errors++;
        end
    endtask

    // Every pop is checked against the oldest expected micro-op
    always @(negedge clk) begin
        CorePkg::RenamedUop e;
        if (!rst && dispValid && dispReady) begin
            if (expQ.size() == 0) begin
                $display("A micro-op was dispatched that was never accepted, at %0t", $time);
                errors++;
            end else begin
                e = expQ.pop_front();
                compareUop(e, dispUop);
            end
        end
    end

    // Lanes are renamed one after the other, so a younger lane sees the older write
    task automatic renameLane(input CorePkg::DecodedUop u);
        CorePkg::RenamedUop e;
        CorePkg::CommitUop c;
        e = '0;
        if (u.valid) begin
            e.fu = u.fu;
            e.imm = u.imm;
            e.archDst = u.rd;
            e.tagA = specMap[u.rs0];
            e.availA = avail[e.tagA];
            e.tagB = specMap[u.rs1];
            e.availB = avail[e.tagB];
            e.sqN = modelSqN;
            modelSqN = modelSqN + 1'b1;
            if (u.rd != '0) begin
                e.tagDst = freeQ.pop_front();
                specMap[u.rd] = e.tagDst;
                avail[e.tagDst] = 1'b0;
                c = '{valid: 1'b1, archDst: u.rd, tagDst: e.tagDst};
                commitQ.push_back(c);
            end
            expQ.push_back(e);
        end
    endtask

    task automatic commitLane(input CorePkg::CommitUop c);
        if (c.valid && c.archDst != '0) begin
            freeQ.push_back(comMap[c.archDst]);
            comMap[c.archDst] = c.tagDst;
            avail[c.tagDst] = 1'b1;
        end
    endtask

    function automatic CorePkg::DecodedUop makeUop(input logic v, input CorePkg::ArchReg rd,
                                                   input CorePkg::ArchReg rs0,
                                                   input CorePkg::ArchReg rs1);
        CorePkg::DecodedUop u;
        u = '0;
        u.valid = v;
        u.fu = CorePkg::FuType'(rs0[1:0]);
        u.rd = rd;
        u.rs0 = rs0;
        u.rs1 = rs1;
        u.imm = {rd, rs0, rs1, 4'ha};
        return u;
    endfunction

    task automatic randomUop(input logic v, input logic needRd, output CorePkg::DecodedUop u);
        logic [31:0] r;
        takeBits(12, r);
        if (needRd && r[11:8] == 4'd0) begin
            r[11:8] = 4'd1;
        end
        u = makeUop(v, needRd ? r[11:8] : 4'd0, r[7:4], r[3:0]);
    endtask

    // Holds the bundle until it is accepted, the model runs before that edge
    task automatic sendBundle(input CorePkg::DecodedUop u0, input CorePkg::DecodedUop u1);
        logic done;
        done = 1'b0;
        @(posedge clk);
        inUops[0] <= u0;
        inUops[1] <= u1;
        while (!done) begin
            @(negedge clk);
            if (inReady) begin
                renameLane(u0);
                renameLane(u1);
                done = 1'b1;
            end
        end
        @(posedge clk);
        inUops[0] <= '0;
        inUops[1] <= '0;
    endtask

    task automatic commitPair(input CorePkg::CommitUop c0, input CorePkg::CommitUop c1);
        @(posedge clk);
        commitUops[0] <= c0;
        commitUops[1] <= c1;
        @(negedge clk);
        commitLane(c0);
        commitLane(c1);
        @(posedge clk);
        commitUops[0] <= '0;
        commitUops[1] <= '0;
    endtask

    task automatic commitOldest();
        CorePkg::CommitUop c0;
        CorePkg::CommitUop c1;
        c0 = commitQ.pop_front();
        c1 = '0;
        if (commitQ.size() > 0) begin
            c1 = commitQ.pop_front();
        end
        commitPair(c0, c1);
    endtask

    task automatic waitDrain();
        @(posedge clk);
        randomReady <= 1'b0;
        // The random driver stops one edge later
        @(posedge clk);
        dispReady <= 1'b1;
        while (expQ.size() > 0) begin
            @(negedge clk);
        end
        // Credits of the last pop need one more edge
        repeat (2) @(negedge clk);
    endtask

    task automatic resetTest();
        CorePkg::DecodedUop u0;
        CorePkg::DecodedUop u1;
        @(negedge clk);
        if (dispValid !== 1'b0) begin
            $display("[FAIL] %0t dispValid expected 0 actual %b", $time, dispValid);
            errors++;
        end
        compareReady(1'b1, inReady);
        compareSqN(8'd0, nextSqN);
        randomUop(1'b1, 1'b1, u0);
        randomUop(1'b1, 1'b1, u1);
        sendBundle(u0, u1);
        waitDrain();
    endtask

    task automatic dependencyTest();
        sendBundle(makeUop(1'b1, 4'd5, 4'd2, 4'd3), makeUop(1'b1, 4'd0, 4'd5, 4'd5));
        waitDrain();
    endtask

    task automatic writebackTest();
        RenamePkg::PhysTag t;
        CorePkg::DecodedUop u0;
        CorePkg::DecodedUop u1;
        t = specMap[5];
        @(posedge clk);
        wbResults[0] <= '{valid: 1'b1, tagDst: t};
        @(negedge clk);
        avail[t] = 1'b1;
        @(posedge clk);
        wbResults[0] <= '0;
        sendBundle(makeUop(1'b1, 4'd6, 4'd5, 4'd1), makeUop(1'b1, 4'd7, 4'd6, 4'd5));
        waitDrain();
        // Writeback on the accepting edge is seen by the lookup on that edge
        t = specMap[6];
        u0 = makeUop(1'b1, 4'd8, 4'd6, 4'd7);
        u1 = makeUop(1'b1, 4'd9, 4'd7, 4'd8);
        @(posedge clk);
        inUops[0] <= u0;
        inUops[1] <= u1;
        wbResults[1] <= '{valid: 1'b1, tagDst: t};
        @(negedge clk);
        compareReady(1'b1, inReady);
        avail[t] = 1'b1;
        renameLane(u0);
        renameLane(u1);
        @(posedge clk);
        inUops[0] <= '0;
        inUops[1] <= '0;
        wbResults[1] <= '0;
        waitDrain();
    endtask

    task automatic commitTest();
        CorePkg::DecodedUop u0;
        CorePkg::DecodedUop u1;
        while (freeQ.size() >= lanes) begin
            randomUop(1'b1, 1'b1, u0);
            randomUop(1'b1, 1'b1, u1);
            sendBundle(u0, u1);
        end
        waitDrain();
        compareReady(1'b0, inReady);
        commitOldest();
        @(negedge clk);
        compareReady(1'b1, inReady);
        // Released tags are handed out again in release order
        repeat (6) begin
            randomUop(1'b1, 1'b1, u0);
            randomUop(1'b1, 1'b1, u1);
            sendBundle(u0, u1);
            commitOldest();
        end
        while (commitQ.size() > 0) begin
            commitOldest();
        end
        waitDrain();
    endtask

    task automatic creditTest();
        CorePkg::DecodedUop u0;
        CorePkg::DecodedUop u1;
        @(posedge clk);
        dispReady <= 1'b0;
        repeat (depth / lanes) begin
            randomUop(1'b1, 1'b0, u0);
            randomUop(1'b1, 1'b1, u1);
            sendBundle(u0, u1);
        end
        @(negedge clk);
        compareReady(1'b0, inReady);
        @(posedge clk);
        randomReady <= 1'b1;
        repeat (5) begin
            randomUop(1'b1, 1'b0, u0);
            randomUop(1'b1, 1'b1, u1);
            sendBundle(u0, u1);
        end
        waitDrain();
        while (commitQ.size() > 0) begin
            commitOldest();
        end
    endtask

    task automatic sequenceTest();
        CorePkg::DecodedUop u0;
        CorePkg::DecodedUop u1;
        logic [31:0] r;
        RenamePkg::SqN prev;
        logic wrapped;
        int n;
        wrapped = 1'b0;
        n = 0;
        // Runs on until the sequence number has wrapped past 255
        while (n < 200 || !wrapped) begin
            takeBits(2, r);
            randomUop(r[1], 1'b0, u0);
            randomUop(r[0], 1'b0, u1);
            prev = modelSqN;
            if (r[1:0] == 2'b00) begin
                @(posedge clk);
            end else begin
                sendBundle(u0, u1);
            end
            @(negedge clk);
            compareSqN(modelSqN, nextSqN);
            if (modelSqN < prev) begin
                wrapped = 1'b1;
            end
            n++;
        end
        waitDrain();
    endtask

    initial begin
        rst = 1'b1;
        dispReady = 1'b1;
        randomReady = 1'b0;
        lfsr = 32'hf07f;
        errors = 0;
        cycles = 0;
        modelSqN = '0;
        for (int i = 0; i < lanes; i++) begin
            inUops[i] = '0;
            commitUops[i] = '0;
            wbResults[i] = '0;
        end
        for (int r = 0; r < RenamePkg::archRegCount; r++) begin
            specMap[r] = RenamePkg::PhysTag'(r);
            comMap[r] = RenamePkg::PhysTag'(r);
        end
        for (int t = 0; t < 64; t++) begin
            avail[t] = 1'b1;
        end
        for (int t = RenamePkg::archRegCount; t < 32; t++) begin
            freeQ.push_back(RenamePkg::PhysTag'(t));
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        resetTest();
        dependencyTest();
        writebackTest();
        commitTest();
        creditTest();
        sequenceTest();
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/RenamePkg.sv
hdl/CorePkg.sv
hdl/RenameTable.sv
hdl/TagBuffer.sv
hdl/Rename.sv
hdl/DispatchQueue.sv
hdl/RenameTop.sv
test/RenameTop_props.sv
test/RenameTb.sv

//--- run.sh
#!/bin/sh
set -e
set -o pipefail 2>/dev/null || true
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module RenameTb -f all.f
./obj_dir/VRenameTb | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
